// ==== conv_core.f ====
+incdir+hw
hw/conv_pkg.sv
hw/ifmap_buffer.sv
hw/weight_buffer.sv
hw/systolic_array.sv
hw/tile_sequencer.sv
hw/ofmap_serializer.sv
hw/conv_core.sv
testbench/conv_core_sva.sv
testbench/conv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f conv_core.f --top-module conv_core_tb -Mdir obj_dir -o conv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/conv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0

// ==== testbench/conv_core_tb.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_core_tb;

  localparam int N          = `ARRAY_DIM;
  localparam int BANK_WORDS = `BANK_VECTORS * `ARRAY_DIM;
  localparam int TILE_WORDS = `ARRAY_DIM * `ARRAY_DIM;
  localparam int JOBS       = 13; // banks over all tests
  localparam int TIMEOUT    = JOBS * (BANK_WORDS + TILE_WORDS) * 40;
  localparam logic [31:0] SEED = 32'h4a5825b7;

  logic                     clk;
  logic                     rst_n;
  logic [`IFMAP_WIDTH-1:0]  ifmap_dat;
  logic                     ifmap_vld;
  logic                     ifmap_rdy;
  logic [`WEIGHT_WIDTH-1:0] weights_dat;
  logic                     weights_vld;
  logic                     weights_rdy;
  logic [`OFMAP_WIDTH-1:0]  ofmap_dat;
  logic                     ofmap_vld;
  logic                     ofmap_rdy;

  logic [15:0] ifmap_q[$];   // still to send
  logic [15:0] weight_q[$];
  logic [15:0] ifmap_sent[$];
  logic [15:0] weight_sent[$];
  logic [31:0] expect_q[$];
  logic [31:0] seed;
  logic [31:0] ifmap_seed;
  logic [31:0] weight_seed;
  int          rdy_mode;     // 0 ready, 1 random, 2 held low
  int          out_count = 0;
  int          jobs_done = 0;
  int          cycles = 0;
  bit          ifmap_stalled = 0;
  bit          weights_stalled = 0;

  conv_core u_conv_core (.*);

  bind conv_core conv_core_sva u_conv_core_sva (
    .clk(clk), .rst_n(rst_n), .ifmap_vld(ifmap_vld), .ifmap_rdy(ifmap_rdy),
    .weights_vld(weights_vld), .weights_rdy(weights_rdy), .ofmap_dat(ofmap_dat),
    .ofmap_vld(ofmap_vld), .ofmap_rdy(ofmap_rdy)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // one bank and one tile, identity-like or large signed values
  task automatic add_job(input bit identity);
    for (int k = 0; k < BANK_WORDS; k++) begin
      seed = lcg(seed);
      ifmap_q.push_back(identity ? 16'(k + 1) : {seed[31], ~seed[31], seed[29:16]});
    end
    for (int k = 0; k < TILE_WORDS; k++) begin
      seed = lcg(seed);
      if (identity) weight_q.push_back((k / N == k % N) ? 16'(k / N + 1) : 16'd0);
      else weight_q.push_back({seed[31], ~seed[31], seed[29:16]});
    end
  endtask

  task automatic send_words(input bit to_weights, input int count, input bit gaps);
    logic [31:0] s;
    s = to_weights ? weight_seed : ifmap_seed;
    for (int k = 0; k < count; k++) begin
      s = lcg(s);
      @(negedge clk);
      if (gaps && s[31:30] != 2'b00) begin
        if (to_weights) weights_vld = 1'b0;
        else ifmap_vld = 1'b0;
        repeat (int'(s[31:30])) @(negedge clk);
      end
      if (to_weights) begin
        weights_dat = weight_q.pop_front();
        weights_vld = 1'b1;
      end else begin
        ifmap_dat = ifmap_q.pop_front();
        ifmap_vld = 1'b1;
      end
      // rdy is stable between falling and rising edge
      while (!(to_weights ? weights_rdy : ifmap_rdy)) @(negedge clk);
      @(posedge clk);
      if (to_weights) weight_sent.push_back(weights_dat);
      else ifmap_sent.push_back(ifmap_dat);
    end
    @(negedge clk);
    if (to_weights) weights_vld = 1'b0;
    else ifmap_vld = 1'b0;
    if (to_weights) weight_seed = s;
    else ifmap_seed = s;
  endtask

  task automatic run_jobs(input int n, input bit gaps);
    fork
      send_words(1'b0, n * BANK_WORDS, gaps);
      send_words(1'b1, n * TILE_WORDS, gaps);
    join
    jobs_done += n;
    wait (out_count == jobs_done * BANK_WORDS);
  endtask

  // one input fully sent, then a pause, then the other
  task automatic run_split(input bit weights_first);
    send_words(weights_first, weights_first ? TILE_WORDS : BANK_WORDS, 1'b1);
    repeat (40) @(negedge clk);
    assert (out_count == jobs_done * BANK_WORDS && !ofmap_vld)
      else fail_now("ofmap words appeared before both bank and tile were sent");
    send_words(!weights_first, weights_first ? BANK_WORDS : TILE_WORDS, 1'b1);
    jobs_done++;
    wait (out_count == jobs_done * BANK_WORDS);
  endtask

  // expected sums for the oldest sent bank and tile
  task automatic compute_tile();
    int acc;
    if (ifmap_sent.size() < BANK_WORDS || weight_sent.size() < TILE_WORDS)
      fail_now("ofmap word arrived without a complete bank and tile sent");
    for (int v = 0; v < `BANK_VECTORS; v++) begin
      for (int j = 0; j < N; j++) begin
        acc = 0;
        for (int i = 0; i < N; i++) begin
          acc += int'($signed(ifmap_sent[v*N+i])) * int'($signed(weight_sent[i*N+j]));
        end
        expect_q.push_back(acc);
      end
    end
    repeat (BANK_WORDS) void'(ifmap_sent.pop_front());
    repeat (TILE_WORDS) void'(weight_sent.pop_front());
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // drives ofmap_rdy and checks the transfer of the coming rising edge
  initial begin : ofmap_sink
    logic [31:0] s;
    s = lcg(SEED ^ 32'h0000_5a5a);
    ofmap_rdy = 1'b1;
    forever begin
      @(negedge clk);
      s = lcg(s);
      ofmap_rdy = (rdy_mode == 0) || (rdy_mode == 1 && s[31:30] != 2'b00);
      if (rst_n && rdy_mode == 2) begin
        if (!ifmap_rdy) ifmap_stalled = 1'b1;
        if (!weights_rdy) weights_stalled = 1'b1;
      end
      if (rst_n && ofmap_vld && ofmap_rdy) begin
        if (expect_q.size() == 0) compute_tile();
        assert (ofmap_dat == expect_q[0])
          else fail_now($sformatf("Error: ofmap_dat expected %h, got %h",
                                  expect_q[0], ofmap_dat));
        void'(expect_q.pop_front());
        out_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) fail_now("timeout, ofmap words stopped before all tests ended");
  end

  initial begin
    rst_n       = 1'b0;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    rdy_mode    = 0;
    seed        = SEED;
    ifmap_seed  = lcg(SEED ^ 32'h0000_00a5);
    weight_seed = lcg(SEED ^ 32'h0000_0c3c);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    add_job(1'b1); // identity-like
    run_jobs(1, 1'b0);
    repeat (2) add_job(1'b0); // wrapping sums
    run_jobs(2, 1'b1);
    repeat (3) add_job(1'b0); // back to back
    run_jobs(3, 1'b0);
    rdy_mode = 1;
    repeat (2) add_job(1'b0);
    run_jobs(2, 1'b1);
    rdy_mode = 2; // long stall until both inputs back up
    repeat (3) add_job(1'b0);
    fork
      run_jobs(3, 1'b0);
      begin
        wait (ifmap_stalled && weights_stalled);
        rdy_mode = 0;
      end
    join
    repeat (2) add_job(1'b0);
    run_split(1'b1);
    run_split(1'b0);
    @(posedge clk); // last checked word transfers here

    if (expect_q.size() == 0 && ifmap_sent.size() == 0 && weight_sent.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_now("sent words left over with no matching ofmap words");
    end
  end

endmodule

// ==== testbench/conv_core_sva.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_core_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    ifmap_vld,
  input logic                    ifmap_rdy,
  input logic                    weights_vld,
  input logic                    weights_rdy,
  input logic [`OFMAP_WIDTH-1:0] ofmap_dat,
  input logic                    ofmap_vld,
  input logic                    ofmap_rdy
);

  // a stalled word stays offered and unchanged
  ofmap_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld && !ofmap_rdy |=> ofmap_vld && $stable(ofmap_dat))
    else $error("ofmap_dat changed while ofmap_vld was high and ofmap_rdy low");

  ctrl_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({ifmap_vld, ifmap_rdy, weights_vld, weights_rdy, ofmap_vld, ofmap_rdy}))
    else $error("handshake signal is unknown after reset");

  dat_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> !$isunknown(ofmap_dat))
    else $error("ofmap_dat is unknown while ofmap_vld is high");

  reset_idle_a: assert property (@(posedge clk) $rose(rst_n) |-> !ofmap_vld)
    else $error("ofmap_vld high right after reset release");

endmodule

// ==== hw/conv_core.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_core (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`IFMAP_WIDTH-1:0]  ifmap_dat,
  input  logic                     ifmap_vld,
  output logic                     ifmap_rdy,
  input  logic [`WEIGHT_WIDTH-1:0] weights_dat,
  input  logic                     weights_vld,
  output logic                     weights_rdy,
  output logic [`OFMAP_WIDTH-1:0]  ofmap_dat,
  output logic                     ofmap_vld,
  input  logic                     ofmap_rdy
);

  logic                             bank_full;
  logic                             tile_full;
  logic                             busy;
  logic                             weight_load;
  logic                             vec_vld;
  logic                             advance;
  logic                             bank_release;
  logic                             tile_release;
  logic                             result_vld;
  logic [$clog2(`BANK_VECTORS)-1:0] vec_idx;
  logic [$clog2(`ARRAY_DIM)-1:0]    row_idx;
  conv_pkg::ifmap_vec_t             vector;
  conv_pkg::weight_row_t            weight_row;
  conv_pkg::psum_vec_t              result;

  ifmap_buffer u_ifmap_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .ifmap_dat    (ifmap_dat),
    .ifmap_vld    (ifmap_vld),
    .vec_idx      (vec_idx),
    .bank_release (bank_release),
    .ifmap_rdy    (ifmap_rdy),
    .bank_full    (bank_full),
    .vector       (vector)
  );

  weight_buffer u_weight_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .weights_dat  (weights_dat),
    .weights_vld  (weights_vld),
    .row_idx      (row_idx),
    .tile_release (tile_release),
    .weights_rdy  (weights_rdy),
    .tile_full    (tile_full),
    .weight_row   (weight_row)
  );

  tile_sequencer u_tile_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank_full    (bank_full),
    .tile_full    (tile_full),
    .busy         (busy),
    .vec_idx      (vec_idx),
    .row_idx      (row_idx),
    .weight_load  (weight_load),
    .vec_vld      (vec_vld),
    .advance      (advance),
    .bank_release (bank_release),
    .tile_release (tile_release)
  );

  systolic_array u_systolic_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (advance),
    .weight_load (weight_load),
    .row_idx     (row_idx),
    .weight_row  (weight_row),
    .vec_vld     (vec_vld),
    .vector      (vector),
    .result_vld  (result_vld),
    .result      (result)
  );

  ofmap_serializer u_ofmap_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .result_vld (result_vld),
    .result     (result),
    .ofmap_rdy  (ofmap_rdy),
    .ofmap_dat  (ofmap_dat),
    .ofmap_vld  (ofmap_vld),
    .busy       (busy)
  );

endmodule

// ==== hw/ofmap_serializer.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module ofmap_serializer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     result_vld,
  input  conv_pkg::psum_vec_t      result,
  input  logic                     ofmap_rdy,
  output logic [`OFMAP_WIDTH-1:0]  ofmap_dat,
  output logic                     ofmap_vld,
  output logic                     busy
);

  localparam int IDX_W = $clog2(`ARRAY_DIM);

  conv_pkg::psum_vec_t hold;
  logic [IDX_W-1:0]    word_idx;
  logic                busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold     <= '0;
      word_idx <= '0;
      busy_q   <= 1'b0;
    end else if (result_vld) begin
      hold     <= result;
      word_idx <= '0;
      busy_q   <= 1'b1;
    end else if (busy_q && ofmap_rdy) begin
      if (word_idx == IDX_W'(`ARRAY_DIM - 1)) busy_q <= 1'b0; // last channel sent
      word_idx <= word_idx + 1'b1;
    end
  end

  assign ofmap_dat = hold[word_idx];
  assign ofmap_vld = busy_q;
  assign busy      = busy_q;

endmodule

// ==== hw/tile_sequencer.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module tile_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              bank_full,
  input  logic                              tile_full,
  input  logic                              busy,
  output logic [$clog2(`BANK_VECTORS)-1:0]  vec_idx,
  output logic [$clog2(`ARRAY_DIM)-1:0]     row_idx,
  output logic                              weight_load,
  output logic                              vec_vld,
  output logic                              advance,
  output logic                              bank_release,
  output logic                              tile_release
);

  localparam int VEC_W        = $clog2(`BANK_VECTORS);
  localparam int ROW_W        = $clog2(`ARRAY_DIM);
  localparam int DRAIN_CYCLES = 2 * `ARRAY_DIM;
  localparam int CNT_W        = $clog2(`BANK_VECTORS > DRAIN_CYCLES ?
                                       `BANK_VECTORS : DRAIN_CYCLES);

  conv_pkg::seq_state_e state;
  logic [CNT_W-1:0]     cnt; // rows, vectors or drain cycles

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= conv_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        conv_pkg::IDLE: begin
          cnt <= '0;
          if (bank_full && tile_full) state <= conv_pkg::PRELOAD;
        end
        conv_pkg::PRELOAD: begin // one weight row per cycle
          if (cnt == CNT_W'(`ARRAY_DIM - 1)) begin
            state <= conv_pkg::STREAM;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        conv_pkg::STREAM: begin
          if (advance) begin
            if (cnt == CNT_W'(`BANK_VECTORS - 1)) begin
              state <= conv_pkg::DRAIN;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        conv_pkg::DRAIN: begin
          if (advance) begin
            if (cnt == CNT_W'(DRAIN_CYCLES - 1)) begin
              state <= conv_pkg::IDLE;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: state <= conv_pkg::IDLE;
      endcase
    end
  end

  assign advance      = ~busy; // serializer full stalls everything
  assign weight_load  = (state == conv_pkg::PRELOAD);
  assign row_idx      = cnt[ROW_W-1:0];
  assign vec_idx      = cnt[VEC_W-1:0];
  assign vec_vld      = (state == conv_pkg::STREAM) & advance;
  // last result leaves the array in this cycle
  assign bank_release = (state == conv_pkg::DRAIN) & advance &
                        (cnt == CNT_W'(DRAIN_CYCLES - 1));
  assign tile_release = bank_release;

endmodule

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module systolic_array (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           advance,
  input  logic                           weight_load,
  input  logic [$clog2(`ARRAY_DIM)-1:0]  row_idx,
  input  conv_pkg::weight_row_t          weight_row,
  input  logic                           vec_vld,
  input  conv_pkg::ifmap_vec_t           vector,
  output logic                           result_vld,
  output conv_pkg::psum_vec_t            result
);

  localparam int N     = `ARRAY_DIM;
  localparam int ROW_W = $clog2(N);
  localparam int LAT   = 2 * `ARRAY_DIM;

  logic [`IFMAP_WIDTH-1:0] a_bus [N][N];   // ifmap into pe (i,j)
  logic [`OFMAP_WIDTH-1:0] p_bus [N+1][N]; // psum into pe (i,j)
  logic [`OFMAP_WIDTH-1:0] col_out [N];
  logic [LAT-1:0]          vld_sr;

  // row i enters i cycles late
  for (genvar i = 0; i < N; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_bus[0][0] = vector[0];
    end else begin : g_dly
      logic [`IFMAP_WIDTH-1:0] sr [i];
      always_ff @(posedge clk) begin
        if (advance) begin
          sr[0] <= vector[i];
          for (int k = 1; k < i; k++) begin
            sr[k] <= sr[k-1];
          end
        end
      end
      assign a_bus[i][0] = sr[i-1];
    end
  end

  for (genvar j = 0; j < N; j++) begin : g_top
    assign p_bus[0][j] = '0;
  end

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_pe
      logic signed [`WEIGHT_WIDTH-1:0] w_q; // stationary
      logic [`OFMAP_WIDTH-1:0]         p_q;
      logic signed [`OFMAP_WIDTH-1:0]  a_ext;
      logic signed [`OFMAP_WIDTH-1:0]  w_ext;

      assign a_ext = `OFMAP_WIDTH'($signed(a_bus[i][j]));
      assign w_ext = `OFMAP_WIDTH'(w_q);

      always_ff @(posedge clk) begin
        if (weight_load && row_idx == ROW_W'(i)) w_q <= weight_row[j];
      end

      always_ff @(posedge clk) begin
        if (advance) p_q <= p_bus[i][j] + a_ext * w_ext;
      end
      assign p_bus[i+1][j] = p_q;

      if (j < N - 1) begin : g_pass
        logic [`IFMAP_WIDTH-1:0] a_q;
        always_ff @(posedge clk) begin
          if (advance) a_q <= a_bus[i][j];
        end
        assign a_bus[i][j+1] = a_q;
      end
    end
  end

  // column j leaves j cycles late, realign
  for (genvar j = 0; j < N; j++) begin : g_deskew
    localparam int D = N - 1 - j;
    if (D == 0) begin : g_direct
      assign col_out[j] = p_bus[N][j];
    end else begin : g_dly
      logic [`OFMAP_WIDTH-1:0] sr [D];
      always_ff @(posedge clk) begin
        if (advance) begin
          sr[0] <= p_bus[N][j];
          for (int k = 1; k < D; k++) begin
            sr[k] <= sr[k-1];
          end
        end
      end
      assign col_out[j] = sr[D-1];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int j = 0; j < N; j++) begin
        result[j] <= col_out[j];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) vld_sr <= '0;
    else if (advance) vld_sr <= {vld_sr[LAT-2:0], vec_vld};
  end

  assign result_vld = vld_sr[LAT-1] & advance; // one strobe per vector even when frozen

endmodule

// ==== hw/weight_buffer.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module weight_buffer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [`WEIGHT_WIDTH-1:0]       weights_dat,
  input  logic                           weights_vld,
  input  logic [$clog2(`ARRAY_DIM)-1:0]  row_idx,
  input  logic                           tile_release,
  output logic                           weights_rdy,
  output logic                           tile_full,
  output conv_pkg::weight_row_t          weight_row
);

  localparam int N     = `ARRAY_DIM;
  localparam int COL_W = $clog2(N);
  localparam int CNT_W = $clog2(N * N);

  conv_pkg::weight_row_t [N-1:0] fill_q;
  conv_pkg::weight_row_t [N-1:0] fill_nxt;
  conv_pkg::weight_row_t [N-1:0] active;
  conv_pkg::weight_row_t [N-1:0] pending;
  logic [CNT_W-1:0]              word_cnt;
  logic                          act_full;
  logic                          pend_full;
  logic                          take;
  logic                          tile_done;
  logic                          act_free;

  assign weights_rdy = ~(act_full & pend_full);
  assign take        = weights_vld & weights_rdy;
  assign tile_done   = take & (word_cnt == CNT_W'(N * N - 1));
  // active slot is empty, or emptied this cycle with nothing pending
  assign act_free    = ~act_full | (tile_release & ~pend_full);

  always_comb begin
    fill_nxt = fill_q;
    fill_nxt[word_cnt[CNT_W-1:COL_W]][word_cnt[COL_W-1:0]] = weights_dat; // w[i][j]
  end

  always_ff @(posedge clk) begin
    if (take) fill_q <= fill_nxt;
    if (tile_release) active <= pending; // promote
    if (tile_done) begin
      if (act_free) active <= fill_nxt;
      else pending <= fill_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt  <= '0;
      act_full  <= 1'b0;
      pend_full <= 1'b0;
    end else begin
      if (tile_done) word_cnt <= '0;
      else if (take) word_cnt <= word_cnt + 1'b1;
      if (tile_release) begin
        act_full  <= pend_full;
        pend_full <= 1'b0;
      end
      if (tile_done) begin
        if (act_free) act_full <= 1'b1;
        else pend_full <= 1'b1;
      end
    end
  end

  assign tile_full  = act_full;
  assign weight_row = active[row_idx];

endmodule

// ==== hw/ifmap_buffer.sv ====
`timescale 1ns/1ps
`include "conv_defines.svh"

module ifmap_buffer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [`IFMAP_WIDTH-1:0]           ifmap_dat,
  input  logic                              ifmap_vld,
  input  logic [$clog2(`BANK_VECTORS)-1:0]  vec_idx,
  input  logic                              bank_release,
  output logic                              ifmap_rdy,
  output logic                              bank_full,
  output conv_pkg::ifmap_vec_t              vector
);

  localparam int WORD_W = $clog2(`ARRAY_DIM);
  localparam int VEC_W  = $clog2(`BANK_VECTORS);

  conv_pkg::ifmap_vec_t mem [2][`BANK_VECTORS];
  conv_pkg::ifmap_vec_t pack_q;
  conv_pkg::ifmap_vec_t pack_nxt;
  logic [WORD_W-1:0]    word_cnt;
  logic [VEC_W-1:0]     vec_cnt;
  logic                 wr_bank;
  logic                 rd_bank;
  logic [1:0]           full;
  logic                 take;
  logic                 vec_done;

  assign ifmap_rdy = ~(full[0] & full[1]);
  assign take      = ifmap_vld & ifmap_rdy;
  assign vec_done  = take & (word_cnt == WORD_W'(`ARRAY_DIM - 1));

  // vector including the word arriving now
  always_comb begin
    pack_nxt = pack_q;
    pack_nxt[word_cnt] = ifmap_dat;
  end

  always_ff @(posedge clk) begin
    if (take) pack_q <= pack_nxt;
    if (vec_done) mem[wr_bank][vec_cnt] <= pack_nxt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      vec_cnt  <= '0;
      wr_bank  <= 1'b0;
      rd_bank  <= 1'b0;
      full     <= '0;
    end else begin
      if (vec_done) word_cnt <= '0;
      else if (take) word_cnt <= word_cnt + 1'b1;
      if (bank_release) begin
        full[rd_bank] <= 1'b0;
        rd_bank <= ~rd_bank;
      end
      if (vec_done) begin
        if (vec_cnt == VEC_W'(`BANK_VECTORS - 1)) begin
          vec_cnt <= '0;
          full[wr_bank] <= 1'b1; // bank complete, hand over
          wr_bank <= ~wr_bank;
        end else begin
          vec_cnt <= vec_cnt + 1'b1;
        end
      end
    end
  end

  assign bank_full = full[rd_bank]; // oldest bank
  assign vector    = mem[rd_bank][vec_idx];

endmodule

// ==== hw/conv_pkg.sv ====
`include "conv_defines.svh"

package conv_pkg;

  // one word per input channel
  typedef logic [`ARRAY_DIM-1:0][`IFMAP_WIDTH-1:0] ifmap_vec_t;

  // weights of one input channel, one per output channel
  typedef logic [`ARRAY_DIM-1:0][`WEIGHT_WIDTH-1:0] weight_row_t;

  typedef logic [`ARRAY_DIM-1:0][`OFMAP_WIDTH-1:0] psum_vec_t; // by output channel

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    STREAM,
    DRAIN
  } seq_state_e;

endpackage

// ==== hw/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// pe grid is ARRAY_DIM x ARRAY_DIM, rows are input channels
`define ARRAY_DIM 4

`define IFMAP_WIDTH 16
`define WEIGHT_WIDTH 16
`define OFMAP_WIDTH 32

// vectors per ifmap bank
`define BANK_VECTORS 8

`endif
